/* Makefile */
# Verilator build and run of the HyperBus AXI front end testbench

VERILATOR ?= verilator
TOP       ?= tb_hyperbus_axi_front
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

/* tb/tb_hyperbus_axi_front.sv */
`timescale 1ns/1ps
// ============================================================
// Seeded random AXI and PHY traffic checked against a model;
// inputs change on the falling edge, outputs sampled 20 ns later
// ============================================================
module tb_hyperbus_axi_front;
    import hyper_axi_pkg::*;
    import hyper_phy_pkg::*;

    localparam int NumBursts = 40;
    localparam int MaxCycles = 20000;

    logic        clk_i;
    logic        rst_ni;
    axi_addr_t   ar_addr_i, aw_addr_i;
    axi_len_t    ar_len_i, aw_len_i;
    logic [1:0]  ar_burst_i, aw_burst_i;
    logic        ar_valid_i, ar_ready_o, aw_valid_i, aw_ready_o;
    axi_data_t   w_data_i, r_data_o;
    axi_strb_t   w_strb_i;
    logic        w_last_i, w_valid_i, w_ready_o;
    axi_resp_t   r_resp_o, b_resp_o;
    logic        r_last_o, r_valid_o, r_ready_i, b_valid_o, b_ready_i;
    phy_word_t   rx_data_i, tx_data_o;
    phy_strb_t   tx_strb_o;
    logic        rx_last_i, rx_error_i, rx_valid_i, rx_ready_o;
    logic        tx_last_o, tx_valid_o, tx_ready_i;
    logic        phy_b_error_i, phy_b_valid_i, phy_b_ready_o;
    logic        trans_write_o, trans_valid_o, trans_ready_i, trans_active_o;
    hyper_addr_t trans_addr_o;
    hyper_blen_t trans_burst_o;
    chip_cs_t    trans_cs_o;

    // Pending AXI requests, PHY read words, W beats and expected outputs
    axi_addr_t ar_addr_q[$], aw_addr_q[$];
    axi_len_t  ar_len_q[$], aw_len_q[$];
    phy_word_t rx_data_q[$], tx_data_q[$];
    logic      rx_last_q[$], rx_err_q[$], tx_last_q[$], w_last_q[$], r_last_q[$];
    phy_strb_t tx_strb_q[$];
    axi_data_t w_data_q[$], r_data_q[$];
    axi_strb_t w_strb_q[$];
    axi_resp_t r_resp_q[$];

    integer seed;
    int     cycle;
    int     tx_count;
    logic   turn_m, lock_m, sel_m, busy_m, wphase_m, b_pend, rbuf_m, rword_m;
    logic   ar_hs, aw_hs, rx_hs, w_hs, pb_hs;

    hyperbus_axi_front dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    function automatic int unsigned rnd(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic stop_with_error(input string what);
        $display("ERROR at %0t: %s", $time, what);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", what);
    endtask

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        assert (act === exp) else begin
            $display("MISMATCH at %0t: %s expected %0h, got %0h", $time, name, exp, act);
            $display("Simulation finished: FAIL");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    // ========================================================
    // Stimulus and expected streams
    // ========================================================

    task automatic make_bursts();
        axi_addr_t addr;
        for (int i = 0; i < NumBursts; i++) begin
            // Random chip, beat-aligned offset inside it
            addr = (rnd(NumChips) << ChipAddrBits) | (rnd(32'h0010_0000) << 3);
            if (rnd(2) == 1) begin
                aw_addr_q.push_back(addr);
                aw_len_q.push_back(axi_len_t'(rnd(8)));
            end else begin
                ar_addr_q.push_back(addr);
                ar_len_q.push_back(axi_len_t'(rnd(8)));
            end
        end
    endtask

    task automatic plan_read(input axi_len_t len);
        phy_word_t lo;
        phy_word_t hi;
        logic      e0;
        logic      e1;
        for (int b = 0; b <= int'(len); b++) begin
            lo = phy_word_t'($random(seed));
            hi = phy_word_t'($random(seed));
            e0 = (rnd(8) == 0);
            e1 = (rnd(8) == 0);
            rx_data_q.push_back(lo);
            rx_err_q.push_back(e0);
            rx_last_q.push_back(1'b0);
            rx_data_q.push_back(hi);
            rx_err_q.push_back(e1);
            rx_last_q.push_back(b == int'(len));
            // Word 0 in the lower half, error if either word failed
            r_data_q.push_back({hi, lo});
            r_resp_q.push_back((e0 | e1) ? RespSlvErr : RespOkay);
            r_last_q.push_back(b == int'(len));
        end
    endtask

    task automatic plan_write(input axi_len_t len);
        phy_word_t lo;
        phy_word_t hi;
        axi_strb_t strb;
        for (int b = 0; b <= int'(len); b++) begin
            lo   = phy_word_t'($random(seed));
            hi   = phy_word_t'($random(seed));
            strb = axi_strb_t'(rnd(256));
            w_data_q.push_back({hi, lo});
            w_strb_q.push_back(strb);
            w_last_q.push_back(b == int'(len));
            tx_data_q.push_back(lo);
            tx_strb_q.push_back(strb[3:0]);
            tx_last_q.push_back(1'b0);
            tx_data_q.push_back(hi);
            tx_strb_q.push_back(strb[7:4]);
            tx_last_q.push_back(b == int'(len));
        end
    endtask

    task automatic drive_inputs();
        if (ar_hs) ar_valid_i = 1'b0;
        if (!ar_valid_i && ar_addr_q.size() > 0 && rnd(3) != 0) begin
            ar_valid_i = 1'b1;
            ar_addr_i  = ar_addr_q[0];
            ar_len_i   = ar_len_q[0];
        end
        if (aw_hs) aw_valid_i = 1'b0;
        if (!aw_valid_i && aw_addr_q.size() > 0 && rnd(3) != 0) begin
            aw_valid_i = 1'b1;
            aw_addr_i  = aw_addr_q[0];
            aw_len_i   = aw_len_q[0];
        end
        if (rx_hs) rx_valid_i = 1'b0;
        if (!rx_valid_i && rx_data_q.size() > 0 && rnd(4) != 0) begin
            rx_valid_i = 1'b1;
            rx_data_i  = rx_data_q[0];
            rx_last_i  = rx_last_q[0];
            rx_error_i = rx_err_q[0];
        end
        if (w_hs) w_valid_i = 1'b0;
        if (!w_valid_i && w_data_q.size() > 0 && rnd(4) != 0) begin
            w_valid_i = 1'b1;
            w_data_i  = w_data_q[0];
            w_strb_i  = w_strb_q[0];
            w_last_i  = w_last_q[0];
        end
        if (pb_hs) phy_b_valid_i = 1'b0;
        if (b_pend && !phy_b_valid_i && rnd(3) == 0) begin
            phy_b_valid_i = 1'b1;
            phy_b_error_i = (rnd(4) == 0);
            b_pend        = 1'b0;
        end
        r_ready_i     = (rnd(4) != 0);
        tx_ready_i    = (rnd(4) != 0);
        trans_ready_i = (rnd(3) != 0);
        b_ready_i     = (rnd(3) != 0);
    endtask

    // ========================================================
    // Reference model, one call per clock cycle
    // ========================================================

    task automatic check_cycle();
        logic      pick, sel, cvalid, t_hs, tx_hs, r_hs, rx_rdy;
        axi_addr_t addr;
        axi_len_t  len;
        // Lone request wins, ties alternate from read, choice held until accepted
        pick   = aw_valid_i & (~ar_valid_i | turn_m);
        sel    = lock_m ? sel_m : pick;
        cvalid = sel ? aw_valid_i : ar_valid_i;
        t_hs   = cvalid & ~busy_m & trans_ready_i;
        check_value("trans_valid_o", cvalid & ~busy_m, trans_valid_o);
        check_value("ar_ready_o", t_hs & ~sel, ar_ready_o);
        check_value("aw_ready_o", t_hs & sel, aw_ready_o);
        check_value("trans_active_o", busy_m, trans_active_o);
        ar_hs  = t_hs & ~sel;
        aw_hs  = t_hs & sel;
        lock_m = cvalid & ~t_hs;
        sel_m  = sel;
        if (t_hs) turn_m = ~turn_m;

        // One-beat R buffer, filled by the upper word
        rx_rdy = ~rbuf_m | r_ready_i;
        check_value("r_valid_o", rbuf_m, r_valid_o);
        check_value("rx_ready_o", rx_rdy, rx_ready_o);
        rx_hs = rx_valid_i & rx_rdy;
        r_hs  = rbuf_m & r_ready_i;
        if (r_hs) begin
            assert (r_data_q.size() > 0)
                else stop_with_error("R beat with no read data pending");
            check_value("r_data_o", r_data_q.pop_front(), r_data_o);
            check_value("r_resp_o", r_resp_q.pop_front(), r_resp_o);
            check_value("r_last_o", r_last_q.pop_front(), r_last_o);
        end
        if (rx_hs && rword_m) begin
            rbuf_m = 1'b1;
        end else if (r_hs) begin
            rbuf_m = 1'b0;
        end
        if (rx_hs) begin
            if (rx_last_i) busy_m = 1'b0;
            rword_m = ~rword_m;
            void'(rx_data_q.pop_front());
            void'(rx_err_q.pop_front());
            void'(rx_last_q.pop_front());
        end

        check_value("tx_valid_o", w_valid_i & wphase_m, tx_valid_o);
        tx_hs = tx_valid_o & tx_ready_i;
        if (tx_hs) begin
            assert (tx_data_q.size() > 0)
                else stop_with_error("PHY write word with no W data pending");
            check_value("tx_data_o", tx_data_q.pop_front(), tx_data_o);
            check_value("tx_strb_o", tx_strb_q.pop_front(), tx_strb_o);
            // The W beat goes with its upper word
            check_value("w_ready_o", tx_count % 2, w_ready_o);
            tx_count++;
            if (tx_last_q[0]) begin
                wphase_m = 1'b0;
                b_pend   = 1'b1;
            end
            check_value("tx_last_o", tx_last_q.pop_front(), tx_last_o);
        end else begin
            check_value("w_ready_o", 1'b0, w_ready_o);
        end
        w_hs = w_valid_i & w_ready_o;
        if (w_hs) begin
            void'(w_data_q.pop_front());
            void'(w_strb_q.pop_front());
            void'(w_last_q.pop_front());
        end

        check_value("b_valid_o", phy_b_valid_i, b_valid_o);
        check_value("phy_b_ready_o", b_ready_i, phy_b_ready_o);
        if (phy_b_valid_i) begin
            check_value("b_resp_o", phy_b_error_i ? RespSlvErr : RespOkay, b_resp_o);
        end
        pb_hs = phy_b_valid_i & b_ready_i;
        if (pb_hs) busy_m = 1'b0;

        if (t_hs) begin
            addr = sel ? aw_addr_i : ar_addr_i;
            len  = sel ? aw_len_i : ar_len_i;
            check_value("trans_write_o", sel, trans_write_o);
            check_value("trans_addr_o", addr[ChipAddrBits-1:0] >> 1, trans_addr_o);
            check_value("trans_cs_o", 1 << addr[ChipAddrBits], trans_cs_o);
            check_value("trans_burst_o", (int'(len) + 1) * 4, trans_burst_o);
            busy_m = 1'b1;
            if (sel) begin
                wphase_m = 1'b1;
                plan_write(len);
                void'(aw_addr_q.pop_front());
                void'(aw_len_q.pop_front());
            end else begin
                plan_read(len);
                void'(ar_addr_q.pop_front());
                void'(ar_len_q.pop_front());
            end
        end
    endtask

    function automatic logic all_done();
        return ar_addr_q.size() == 0 && aw_addr_q.size() == 0 && r_data_q.size() == 0
            && !busy_m && !ar_valid_i && !aw_valid_i;
    endfunction

    initial begin
        seed = 32'hfd4c70ae;
        {ar_addr_i, ar_len_i, ar_valid_i, aw_addr_i, aw_len_i, aw_valid_i} = '0;
        {w_data_i, w_strb_i, w_last_i, w_valid_i, r_ready_i, b_ready_i} = '0;
        {rx_data_i, rx_last_i, rx_error_i, rx_valid_i, tx_ready_i} = '0;
        {phy_b_error_i, phy_b_valid_i, trans_ready_i} = '0;
        {turn_m, lock_m, sel_m, busy_m, wphase_m, b_pend, rbuf_m, rword_m} = '0;
        {ar_hs, aw_hs, rx_hs, w_hs, pb_hs} = '0;
        ar_burst_i = BurstIncr;
        aw_burst_i = BurstIncr;
        tx_count   = 0;
        rst_ni     = 1'b0;
        make_bursts();
        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        check_value("trans_valid_o", 1'b0, trans_valid_o);
        check_value("trans_active_o", 1'b0, trans_active_o);
        check_value("r_valid_o", 1'b0, r_valid_o);
        check_value("tx_valid_o", 1'b0, tx_valid_o);
        check_value("w_ready_o", 1'b0, w_ready_o);
        check_value("ar_ready_o", 1'b0, ar_ready_o);
        check_value("aw_ready_o", 1'b0, aw_ready_o);
        rst_ni = 1'b1;
        cycle  = 0;
        while (!all_done()) begin
            if (cycle == MaxCycles) stop_with_error("Timeout while waiting for the bursts to end");
            @(negedge clk_i);
            drive_inputs();
            #20;
            check_cycle();
            cycle++;
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* verilog.f */
verilog/hyper_axi_pkg.sv
verilog/hyper_phy_pkg.sv
verilog/ax_cmd_if.sv
verilog/ax_arbiter.sv
verilog/transfer_fsm.sv
verilog/burst_counter.sv
verilog/read_coalescer.sv
verilog/write_splitter.sv
verilog/hyperbus_axi_front.sv
tb/tb_hyperbus_axi_front.sv

/* verilog/ax_arbiter.sv */
`timescale 1ns/1ps
// ============================================================
// Round-robin AR/AW arbiter; the choice holds until handshake
// ============================================================
module ax_arbiter (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  hyper_axi_pkg::axi_addr_t ar_addr_i,
    input  hyper_axi_pkg::axi_len_t  ar_len_i,
    input  logic                     ar_valid_i,
    output logic                     ar_ready_o,
    input  hyper_axi_pkg::axi_addr_t aw_addr_i,
    input  hyper_axi_pkg::axi_len_t  aw_len_i,
    input  logic                     aw_valid_i,
    output logic                     aw_ready_o,
    ax_cmd_if.src                    cmd
);

    logic turn_q;
    logic lock_q;
    logic sel_q;
    logic pick_write;
    logic sel_write;
    logic cmd_hs;

    // A lone request wins, a tie goes to the turn bit (0 = read)
    assign pick_write = aw_valid_i & (~ar_valid_i | turn_q);
    assign sel_write  = lock_q ? sel_q : pick_write;

    assign cmd.valid = sel_write ? aw_valid_i : ar_valid_i;
    assign cmd.write = sel_write;
    assign cmd.addr  = sel_write ? aw_addr_i : ar_addr_i;
    assign cmd.len   = sel_write ? aw_len_i : ar_len_i;

    assign cmd_hs     = cmd.valid & cmd.ready;
    assign ar_ready_o = cmd_hs & ~sel_write;
    assign aw_ready_o = cmd_hs & sel_write;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            turn_q <= 1'b0;
            lock_q <= 1'b0;
            sel_q  <= 1'b0;
        end else begin
            // Hold the winner while its request waits
            lock_q <= cmd.valid & ~cmd.ready;
            sel_q  <= sel_write;
            if (cmd_hs) begin
                turn_q <= ~turn_q;
            end
        end
    end

endmodule

/* verilog/ax_cmd_if.sv */
`timescale 1ns/1ps
// ============================================================
// Arbitrated AR/AW request; payload holds until valid & ready
// ============================================================
interface ax_cmd_if;
    import hyper_axi_pkg::*;

    logic      valid;
    logic      ready;
    logic      write;
    axi_addr_t addr;
    axi_len_t  len;

    modport src (output valid, write, addr, len, input ready);
    modport dst (input valid, write, addr, len, output ready);
    modport mon (input valid, ready, write, addr, len);

endinterface

/* verilog/burst_counter.sv */
`timescale 1ns/1ps
// ============================================================
// Word and beat position of the active burst (two words/beat)
// ============================================================
module burst_counter (
    input  logic  clk_i,
    input  logic  rst_ni,
    ax_cmd_if.mon cmd,
    input  logic  word_hs_i,
    output logic  word_idx_o,
    output logic  final_word_o
);
    import hyper_axi_pkg::*;

    // Beats left after the current one
    axi_len_t beats_q;
    logic     word_q;
    logic     live_q;

    assign word_idx_o   = word_q;
    assign final_word_o = word_q & (beats_q == '0);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            beats_q <= '0;
            word_q  <= 1'b0;
            live_q  <= 1'b0;
        end else if (cmd.valid && cmd.ready) begin
            beats_q <= cmd.len;
            word_q  <= 1'b0;
            live_q  <= 1'b1;
        end else if (word_hs_i && live_q) begin
            word_q <= ~word_q;
            if (final_word_o) begin
                live_q <= 1'b0;
            end else if (word_q) begin
                beats_q <= beats_q - 1'b1;
            end
        end
    end

    a_no_overrun: assert property (@(posedge clk_i) disable iff (!rst_ni)
        word_hs_i |-> live_q)
        else $error("Word handshake after the final word of the burst");

endmodule

/* verilog/hyper_axi_pkg.sv */
// ============================================================
// AXI-side constants and types; only full 64-bit INCR bursts
// on beat-aligned addresses are supported
// ============================================================
package hyper_axi_pkg;

    localparam int unsigned AxiAddrWidth = 32;
    localparam int unsigned AxiDataWidth = 64;
    localparam int unsigned WordsPerBeat = 2;

    typedef logic [AxiAddrWidth-1:0]   axi_addr_t;
    // Number of beats minus one
    typedef logic [7:0]                axi_len_t;
    typedef logic [AxiDataWidth-1:0]   axi_data_t;
    typedef logic [AxiDataWidth/8-1:0] axi_strb_t;
    typedef logic [1:0]                axi_resp_t;

    localparam axi_resp_t  RespOkay   = 2'd0;
    localparam axi_resp_t  RespSlvErr = 2'd2;
    localparam logic [1:0] BurstIncr  = 2'd1;

    // One beat, seen whole or as its PHY words (word 0 is the lower half)
    typedef union packed {
        axi_data_t                                               beat;
        logic [WordsPerBeat-1:0][AxiDataWidth/WordsPerBeat-1:0] words;
    } axi_beat_u;

endpackage

/* verilog/hyper_phy_pkg.sv */
// ============================================================
// PHY-side constants and types; two chips of 8 MiB each,
// selected by the address bit just above the in-chip range
// ============================================================
package hyper_phy_pkg;

    localparam int unsigned PhyWordWidth    = 32;
    localparam int unsigned NumChips        = 2;
    localparam int unsigned ChipAddrBits    = 23;
    localparam int unsigned ChipSelWidth    = 1;
    localparam int unsigned HyperBurstWidth = 16;

    typedef logic [PhyWordWidth-1:0]    phy_word_t;
    typedef logic [PhyWordWidth/8-1:0]  phy_strb_t;
    // Address of a 16-bit word inside the selected chip
    typedef logic [31:0]                hyper_addr_t;
    // Burst length counted in 16-bit words
    typedef logic [HyperBurstWidth-1:0] hyper_blen_t;
    // One-hot
    typedef logic [NumChips-1:0]        chip_cs_t;

endpackage

/* verilog/hyperbus_axi_front.sv */
`timescale 1ns/1ps
// ============================================================
// AXI front end of a HyperBus controller; no IDs, INCR only,
// full 64-bit beats on aligned addresses
// ============================================================
module hyperbus_axi_front (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // AXI
    input  hyper_axi_pkg::axi_addr_t   ar_addr_i,
    input  hyper_axi_pkg::axi_len_t    ar_len_i,
    input  logic [1:0]                 ar_burst_i,
    input  logic                       ar_valid_i,
    output logic                       ar_ready_o,
    input  hyper_axi_pkg::axi_addr_t   aw_addr_i,
    input  hyper_axi_pkg::axi_len_t    aw_len_i,
    input  logic [1:0]                 aw_burst_i,
    input  logic                       aw_valid_i,
    output logic                       aw_ready_o,
    input  hyper_axi_pkg::axi_data_t   w_data_i,
    input  hyper_axi_pkg::axi_strb_t   w_strb_i,
    input  logic                       w_last_i,
    input  logic                       w_valid_i,
    output logic                       w_ready_o,
    output hyper_axi_pkg::axi_data_t   r_data_o,
    output hyper_axi_pkg::axi_resp_t   r_resp_o,
    output logic                       r_last_o,
    output logic                       r_valid_o,
    input  logic                       r_ready_i,
    output hyper_axi_pkg::axi_resp_t   b_resp_o,
    output logic                       b_valid_o,
    input  logic                       b_ready_i,
    // PHY
    input  hyper_phy_pkg::phy_word_t   rx_data_i,
    input  logic                       rx_last_i,
    input  logic                       rx_error_i,
    input  logic                       rx_valid_i,
    output logic                       rx_ready_o,
    output hyper_phy_pkg::phy_word_t   tx_data_o,
    output hyper_phy_pkg::phy_strb_t   tx_strb_o,
    output logic                       tx_last_o,
    output logic                       tx_valid_o,
    input  logic                       tx_ready_i,
    input  logic                       phy_b_error_i,
    input  logic                       phy_b_valid_i,
    output logic                       phy_b_ready_o,
    // Transfer command and status
    output logic                       trans_write_o,
    output hyper_phy_pkg::hyper_addr_t trans_addr_o,
    output hyper_phy_pkg::hyper_blen_t trans_burst_o,
    output hyper_phy_pkg::chip_cs_t    trans_cs_o,
    output logic                       trans_valid_o,
    input  logic                       trans_ready_i,
    output logic                       trans_active_o
);
    import hyper_axi_pkg::*;

    logic rx_hs;
    logic tx_hs;
    logic word_idx;
    logic final_word;
    logic wdata_phase;

    ax_cmd_if cmd_if ();

    assign rx_hs = rx_valid_i & rx_ready_o;
    assign tx_hs = tx_valid_o & tx_ready_i;

    // ========================================================
    // Request path
    // ========================================================

    ax_arbiter i_ax_arbiter (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .ar_addr_i  (ar_addr_i),
        .ar_len_i   (ar_len_i),
        .ar_valid_i (ar_valid_i),
        .ar_ready_o (ar_ready_o),
        .aw_addr_i  (aw_addr_i),
        .aw_len_i   (aw_len_i),
        .aw_valid_i (aw_valid_i),
        .aw_ready_o (aw_ready_o),
        .cmd        (cmd_if.src)
    );

    transfer_fsm i_transfer_fsm (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .cmd            (cmd_if.dst),
        .ar_burst_i     (ar_burst_i),
        .aw_burst_i     (aw_burst_i),
        .trans_write_o  (trans_write_o),
        .trans_addr_o   (trans_addr_o),
        .trans_burst_o  (trans_burst_o),
        .trans_cs_o     (trans_cs_o),
        .trans_valid_o  (trans_valid_o),
        .trans_ready_i  (trans_ready_i),
        .rx_last_i      (rx_last_i),
        .rx_hs_i        (rx_hs),
        .tx_last_hs_i   (tx_hs & tx_last_o),
        .phy_b_hs_i     (phy_b_valid_i & phy_b_ready_o),
        .wdata_phase_o  (wdata_phase),
        .trans_active_o (trans_active_o)
    );

    // Reads and writes never overlap, so one counter serves both
    burst_counter i_burst_counter (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .cmd          (cmd_if.mon),
        .word_hs_i    (rx_hs | tx_hs),
        .word_idx_o   (word_idx),
        .final_word_o (final_word)
    );

    // ========================================================
    // Data paths
    // ========================================================

    read_coalescer i_read_coalescer (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .rx_data_i    (rx_data_i),
        .rx_last_i    (rx_last_i),
        .rx_error_i   (rx_error_i),
        .rx_valid_i   (rx_valid_i),
        .rx_ready_o   (rx_ready_o),
        .word_idx_i   (word_idx),
        .final_word_i (final_word),
        .r_data_o     (r_data_o),
        .r_resp_o     (r_resp_o),
        .r_last_o     (r_last_o),
        .r_valid_o    (r_valid_o),
        .r_ready_i    (r_ready_i)
    );

    write_splitter i_write_splitter (
        .w_data_i      (w_data_i),
        .w_strb_i      (w_strb_i),
        .w_last_i      (w_last_i),
        .w_valid_i     (w_valid_i),
        .w_ready_o     (w_ready_o),
        .wdata_phase_i (wdata_phase),
        .word_idx_i    (word_idx),
        .final_word_i  (final_word),
        .tx_data_o     (tx_data_o),
        .tx_strb_o     (tx_strb_o),
        .tx_last_o     (tx_last_o),
        .tx_valid_o    (tx_valid_o),
        .tx_ready_i    (tx_ready_i)
    );

    // Write response straight from the PHY
    assign b_valid_o     = phy_b_valid_i;
    assign phy_b_ready_o = b_ready_i;
    assign b_resp_o      = phy_b_error_i ? RespSlvErr : RespOkay;

endmodule

/* verilog/read_coalescer.sv */
`timescale 1ns/1ps
// ============================================================
// Packs two PHY words into one R beat; one-beat buffer, so a
// new word is taken only while the held beat pops
// ============================================================
module read_coalescer (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    input  hyper_phy_pkg::phy_word_t   rx_data_i,
    input  logic                       rx_last_i,
    input  logic                       rx_error_i,
    input  logic                       rx_valid_i,
    output logic                       rx_ready_o,
    input  logic                       word_idx_i,
    input  logic                       final_word_i,
    output hyper_axi_pkg::axi_data_t   r_data_o,
    output hyper_axi_pkg::axi_resp_t   r_resp_o,
    output logic                       r_last_o,
    output logic                       r_valid_o,
    input  logic                       r_ready_i
);
    import hyper_axi_pkg::*;

    axi_beat_u buf_q;
    logic      last_q;
    logic      valid_q;
    logic      err_q;
    logic      rx_hs;
    logic      pop;
    logic      beat_done;

    assign rx_ready_o = ~valid_q | r_ready_i;
    assign rx_hs      = rx_valid_i & rx_ready_o;
    assign pop        = valid_q & r_ready_i;
    assign beat_done  = word_idx_i | rx_last_i;

    always_ff @(posedge clk_i) begin
        if (rx_hs) begin
            buf_q.words[word_idx_i] <= rx_data_i;
            last_q                  <= rx_last_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            if (rx_hs && beat_done) begin
                valid_q <= 1'b1;
            end else if (pop) begin
                valid_q <= 1'b0;
            end
            // Sticky over the words of one beat
            err_q <= (err_q & ~pop) | (rx_hs & rx_error_i);
        end
    end

    assign r_data_o  = buf_q.beat;
    assign r_resp_o  = err_q ? RespSlvErr : RespOkay;
    assign r_last_o  = last_q;
    assign r_valid_o = valid_q;

    a_rx_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rx_hs |-> (rx_last_i == final_word_i))
        else $error("PHY read length differs from the AXI burst");

endmodule

/* verilog/transfer_fsm.sv */
`timescale 1ns/1ps
// ============================================================
// One transfer at a time; new commands only while idle
// ============================================================
module transfer_fsm (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    ax_cmd_if.dst                      cmd,
    input  logic [1:0]                 ar_burst_i,
    input  logic [1:0]                 aw_burst_i,
    output logic                       trans_write_o,
    output hyper_phy_pkg::hyper_addr_t trans_addr_o,
    output hyper_phy_pkg::hyper_blen_t trans_burst_o,
    output hyper_phy_pkg::chip_cs_t    trans_cs_o,
    output logic                       trans_valid_o,
    input  logic                       trans_ready_i,
    input  logic                       rx_last_i,
    input  logic                       rx_hs_i,
    input  logic                       tx_last_hs_i,
    input  logic                       phy_b_hs_i,
    output logic                       wdata_phase_o,
    output logic                       trans_active_o
);
    import hyper_axi_pkg::*;
    import hyper_phy_pkg::*;

    enum logic [1:0] {StIdle, StRead, StWrite} state_q, state_d;
    logic                    idle;
    logic                    trans_hs;
    logic                    wdata_q;
    logic [ChipSelWidth-1:0] chip_idx;

    assign idle          = (state_q == StIdle);
    assign trans_valid_o = cmd.valid & idle;
    assign cmd.ready     = trans_ready_i & idle;
    assign trans_hs      = trans_valid_o & trans_ready_i;

    // ========================================================
    // Command conversion
    // ========================================================

    assign trans_write_o = cmd.write;
    assign chip_idx      = cmd.addr[ChipAddrBits +: ChipSelWidth];
    assign trans_addr_o  = hyper_addr_t'(cmd.addr[ChipAddrBits-1:1]);
    // Four 16-bit words per beat
    assign trans_burst_o = (hyper_blen_t'(cmd.len) + hyper_blen_t'(1)) << 2;

    always_comb begin
        trans_cs_o           = '0;
        trans_cs_o[chip_idx] = 1'b1;
    end

    // ========================================================
    // State and status
    // ========================================================

    always_comb begin
        state_d = state_q;
        case (state_q)
            StIdle: begin
                if (trans_hs) begin
                    state_d = cmd.write ? StWrite : StRead;
                end
            end
            StRead: begin
                if (rx_hs_i && rx_last_i) begin
                    state_d = StIdle;
                end
            end
            StWrite: begin
                // Done once the PHY write response is handed to B
                if (phy_b_hs_i) begin
                    state_d = StIdle;
                end
            end
            default: state_d = StIdle;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= StIdle;
            wdata_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (trans_hs && cmd.write) begin
                wdata_q <= 1'b1;
            end else if (tx_last_hs_i) begin
                wdata_q <= 1'b0;
            end
        end
    end

    assign wdata_phase_o  = wdata_q;
    assign trans_active_o = ~idle;

    a_burst_incr: assert property (@(posedge clk_i) disable iff (!rst_ni)
        trans_hs |-> ((cmd.write ? aw_burst_i : ar_burst_i) == BurstIncr))
        else $error("Only INCR bursts are supported");

    a_beat_align: assert property (@(posedge clk_i) disable iff (!rst_ni)
        trans_hs |-> (cmd.addr[2:0] == 3'b000))
        else $error("Burst address is not 8-byte aligned");

endmodule

/* verilog/write_splitter.sv */
`timescale 1ns/1ps
// ============================================================
// Splits W beats into two PHY words, lower half first
// ============================================================
module write_splitter (
    input  hyper_axi_pkg::axi_data_t w_data_i,
    input  hyper_axi_pkg::axi_strb_t w_strb_i,
    input  logic                     w_last_i,
    input  logic                     w_valid_i,
    output logic                     w_ready_o,
    input  logic                     wdata_phase_i,
    input  logic                     word_idx_i,
    input  logic                     final_word_i,
    output hyper_phy_pkg::phy_word_t tx_data_o,
    output hyper_phy_pkg::phy_strb_t tx_strb_o,
    output logic                     tx_last_o,
    output logic                     tx_valid_o,
    input  logic                     tx_ready_i
);
    import hyper_phy_pkg::*;

    assign tx_data_o  = w_data_i[word_idx_i*PhyWordWidth +: PhyWordWidth];
    assign tx_strb_o  = w_strb_i[word_idx_i*(PhyWordWidth/8) +: PhyWordWidth/8];
    assign tx_last_o  = final_word_i;
    assign tx_valid_o = w_valid_i & wdata_phase_i;

    // The beat is consumed with its upper word
    assign w_ready_o = tx_valid_o & tx_ready_i & word_idx_i;

    always_comb begin
        if (w_valid_i && w_ready_o) begin
            a_w_last: assert final (w_last_i == final_word_i)
                else $error("W last does not match the burst length");
        end
    end

endmodule
